// File: src/rxcal_cfg_pkg.sv
//==============================
// Calibration configuration: sizes, derived widths,
// offset code and lane index types
//==============================
package rxcal_cfg_pkg;

  localparam int NUM_LANES    = 8;  // Receive lanes under calibration
  localparam int CODE_W       = 5;  // Offset trim code width
  localparam int LANE_W       = 3;  // Lane index width
  localparam int DIV_W        = 7;  // One-hot divider choices, /1 to /64
  localparam int SETTLE_TICKS = 4;  // Ticks between trial change and compare

  // Derived widths
  localparam int PTR_W    = $clog2(CODE_W);        // SAR bit pointer
  localparam int SETTLE_W = $clog2(SETTLE_TICKS);  // Settle counter
  localparam int DIVCNT_W = DIV_W - 1;             // Divider counter, up to /64

  typedef logic [CODE_W-1:0] code_t;
  typedef logic [LANE_W-1:0] lane_t;

  // Handy constants
  localparam logic [DIV_W-1:0]    DIV_SEL_RST = DIV_W'(1);  // Divide by 1 out of reset
  localparam logic [PTR_W-1:0]    CODE_MSB    = PTR_W'(CODE_W - 1);
  localparam logic [SETTLE_W-1:0] SETTLE_LAST = SETTLE_W'(SETTLE_TICKS - 1);
  localparam lane_t               LANE_LAST   = lane_t'(NUM_LANES - 1);

endpackage

// File: src/rxcal_state_pkg.sv
//==============================
// FSM state encodings for the lane
// sequencer and the SAR search engine
//==============================
package rxcal_state_pkg;

  // Lane sequencer
  typedef enum logic [2:0] {
    SEQ_IDLE,   // Waiting for start_cal edge
    SEQ_START,  // Launch search on current lane
    SEQ_WAIT,   // Search in flight
    SEQ_NEXT,   // Step to next lane or finish
    SEQ_DONE    // All lanes calibrated, hold done
  } seq_state_t;

  // Successive approximation engine
  typedef enum logic [1:0] {
    SAR_IDLE,    // No search running
    SAR_SET,     // Set current trial bit on tick
    SAR_SETTLE,  // Let comparator settle
    SAR_DECIDE   // Keep or drop the bit
  } sar_state_t;

endpackage

// File: src/rxcal_if.sv
//==============================
// One lane search: sequencer, engine and code bank
//==============================
interface rxcal_if;

  logic                 start;   // Launch pulse, engine must be idle
  rxcal_cfg_pkg::code_t trial;   // Code under test on the active lane
  rxcal_cfg_pkg::code_t result;  // Final code, valid with done
  logic                 done;    // Single-cycle end of search
  logic                 sample;  // Synchronized comparator bit

  // Sequencer launches and waits
  modport seq (output start, input done);

  // Engine runs the search
  modport eng (input start, input sample, output trial, output result, output done);

  // Bank drives the lane and returns its comparator
  modport bank (input trial, input result, output sample);

endinterface

// File: src/rxcal_rate_div.sv
//==============================
// Calibration rate divider: one-hot
// select load, ack and tick enable
//==============================
module rxcal_rate_div (
  input  logic                              sys_clk,
  input  logic                              arst_n,
  input  logic                              clk_div_ld,
  input  logic [rxcal_cfg_pkg::DIV_W-1:0]   clk_div_onehot,
  output logic                              cal_tick,
  output logic                              clk_div_ld_ack
);

  logic [rxcal_cfg_pkg::DIV_W-1:0]    sel_q;   // Latched one-hot select
  logic [rxcal_cfg_pkg::DIVCNT_W-1:0] cnt_q;   // Free-running count
  logic [rxcal_cfg_pkg::DIVCNT_W-1:0] mask;    // Low bits that must wrap

  // Mask bit i is set when the selected ratio is above 2^i
  always_comb
  begin
    mask = '0;
    for (int i = 0; i < rxcal_cfg_pkg::DIVCNT_W; i++)
    begin
      mask[i] = |(sel_q >> (i + 1));
    end
  end

  always_ff @(posedge sys_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sel_q          <= rxcal_cfg_pkg::DIV_SEL_RST;
      cnt_q          <= '0;
      clk_div_ld_ack <= 1'b0;
    end
    else
    begin
      clk_div_ld_ack <= clk_div_ld;  // Follows ld one cycle late
      if (clk_div_ld)
      begin
        sel_q <= clk_div_onehot;
        cnt_q <= '0;                 // Restart phase on new ratio
      end
      else
      begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign cal_tick = ((cnt_q & mask) == mask);  // Wrap of the low k bits

  // Loaded select must stay one-hot so the tick period is defined
  a_sel_onehot: assert property (@(posedge sys_clk) disable iff (!arst_n)
    clk_div_ld |=> $onehot(sel_q));

endmodule

// File: src/rxcal_sar_engine.sv
//==============================
// SAR search of one lane's offset code
//==============================
module rxcal_sar_engine (
  input  logic sys_clk,
  input  logic arst_n,
  input  logic cal_tick,
  rxcal_if.eng cal
);

  rxcal_state_pkg::sar_state_t        state_q;
  logic [rxcal_cfg_pkg::PTR_W-1:0]    bit_q;        // Bit under decision
  logic [rxcal_cfg_pkg::SETTLE_W-1:0] settle_q;     // Ticks waited so far
  rxcal_cfg_pkg::code_t               trial_q;
  rxcal_cfg_pkg::code_t               decide_code;  // Trial after the decision
  logic                               done_q;

  // Comparator high means trial is at or above threshold, drop the bit
  always_comb
  begin
    decide_code = trial_q;
    if (cal.sample)
    begin
      decide_code[bit_q] = 1'b0;
    end
  end

  always_ff @(posedge sys_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q  <= rxcal_state_pkg::SAR_IDLE;
      bit_q    <= '0;
      settle_q <= '0;
      trial_q  <= '0;
      done_q   <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      case (state_q)
        rxcal_state_pkg::SAR_IDLE:
        begin
          if (cal.start)
          begin
            trial_q <= '0;                      // Search from zero, MSB first
            bit_q   <= rxcal_cfg_pkg::CODE_MSB;
            state_q <= rxcal_state_pkg::SAR_SET;
          end
        end
        rxcal_state_pkg::SAR_SET:
        begin
          if (cal_tick)
          begin
            trial_q[bit_q] <= 1'b1;
            settle_q       <= '0;
            state_q        <= rxcal_state_pkg::SAR_SETTLE;
          end
        end
        rxcal_state_pkg::SAR_SETTLE:
        begin
          if (cal_tick)
          begin
            if (settle_q == rxcal_cfg_pkg::SETTLE_LAST)
              state_q <= rxcal_state_pkg::SAR_DECIDE;
            else
              settle_q <= settle_q + 1'b1;
          end
        end
        rxcal_state_pkg::SAR_DECIDE:
        begin
          trial_q <= decide_code;
          if (bit_q == '0)
          begin
            done_q  <= 1'b1;                    // LSB decided, report
            state_q <= rxcal_state_pkg::SAR_IDLE;
          end
          else
          begin
            bit_q   <= bit_q - 1'b1;
            state_q <= rxcal_state_pkg::SAR_SET;
          end
        end
        default: state_q <= rxcal_state_pkg::SAR_IDLE;
      endcase
    end
  end

  assign cal.trial  = trial_q;
  assign cal.result = trial_q;  // Final trial once done pulses
  assign cal.done   = done_q;

  // Sequencer may only launch into an idle engine
  a_start_idle: assert property (@(posedge sys_clk) disable iff (!arst_n)
    cal.start |-> state_q == rxcal_state_pkg::SAR_IDLE);

endmodule

// File: src/rxcal_code_bank.sv
//==============================
// Per-lane code storage, trial drive
// and comparator sample synchronizer
//==============================
module rxcal_code_bank (
  input  logic                                 sys_clk,
  input  logic                                 arst_n,
  input  logic [rxcal_cfg_pkg::NUM_LANES-1:0]  ana_rxdata,
  input  rxcal_cfg_pkg::lane_t                 lane,
  input  logic                                 cal_active,
  input  logic                                 wr_en,
  rxcal_if.bank                                cal,
  output rxcal_cfg_pkg::code_t [rxcal_cfg_pkg::NUM_LANES-1:0] lane_code
);

  rxcal_cfg_pkg::code_t [rxcal_cfg_pkg::NUM_LANES-1:0] code_q;  // Calibrated codes
  logic [1:0] sync_q;  // Two-flop synchronizer

  //==============================
  // Code storage
  //==============================
  always_ff @(posedge sys_clk or negedge arst_n)
  begin
    if (!arst_n)
      code_q <= '0;                  // Lanes start untrimmed
    else if (wr_en)
      code_q[lane] <= cal.result;    // Keep the search result
  end

  // Lane under calibration sees the trial code
  always_comb
  begin
    for (int i = 0; i < rxcal_cfg_pkg::NUM_LANES; i++)
    begin
      if (cal_active && (lane == rxcal_cfg_pkg::lane_t'(i)))
        lane_code[i] = cal.trial;
      else
        lane_code[i] = code_q[i];
    end
  end

  //==============================
  // Comparator sampling
  //==============================
  always_ff @(posedge sys_clk or negedge arst_n)
  begin
    if (!arst_n)
      sync_q <= '0;
    else
      sync_q <= {sync_q[0], ana_rxdata[lane]};  // Selected lane only
  end

  assign cal.sample = sync_q[1];

endmodule

// File: src/rxcal_sequencer.sv
//==============================
// Lane sequencer FSM: start edge,
// per-lane launch and write, run/done
//==============================
module rxcal_sequencer (
  input  logic                 sys_clk,
  input  logic                 arst_n,
  input  logic                 start_cal,
  rxcal_if.seq                 cal,
  output rxcal_cfg_pkg::lane_t lane,
  output logic                 cal_active,
  output logic                 wr_en,
  output logic                 cal_run,
  output logic                 cal_done_int
);

  rxcal_state_pkg::seq_state_t state_q;
  rxcal_cfg_pkg::lane_t        lane_q;
  logic                        start_q;     // Previous start_cal
  logic                        start_rise;

  assign start_rise = start_cal && !start_q;

  always_ff @(posedge sys_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q <= rxcal_state_pkg::SEQ_IDLE;
      lane_q  <= '0;
      start_q <= 1'b0;
    end
    else
    begin
      start_q <= start_cal;
      case (state_q)
        rxcal_state_pkg::SEQ_IDLE,
        rxcal_state_pkg::SEQ_DONE:
        begin
          if (start_rise)  // Edges during a run are ignored
          begin
            lane_q  <= '0;
            state_q <= rxcal_state_pkg::SEQ_START;
          end
        end
        rxcal_state_pkg::SEQ_START: state_q <= rxcal_state_pkg::SEQ_WAIT;
        rxcal_state_pkg::SEQ_WAIT:
        begin
          if (cal.done)
            state_q <= rxcal_state_pkg::SEQ_NEXT;
        end
        rxcal_state_pkg::SEQ_NEXT:
        begin
          if (lane_q == rxcal_cfg_pkg::LANE_LAST)
          begin
            state_q <= rxcal_state_pkg::SEQ_DONE;
          end
          else
          begin
            lane_q  <= lane_q + 1'b1;
            state_q <= rxcal_state_pkg::SEQ_START;
          end
        end
        default: state_q <= rxcal_state_pkg::SEQ_IDLE;
      endcase
    end
  end

  assign cal.start    = (state_q == rxcal_state_pkg::SEQ_START);  // One pulse per lane
  assign wr_en        = (state_q == rxcal_state_pkg::SEQ_WAIT) && cal.done;
  assign lane         = lane_q;
  assign cal_active   = (state_q == rxcal_state_pkg::SEQ_START) ||
                        (state_q == rxcal_state_pkg::SEQ_WAIT);
  assign cal_run      = cal_active || (state_q == rxcal_state_pkg::SEQ_NEXT);
  assign cal_done_int = (state_q == rxcal_state_pkg::SEQ_DONE);  // Held until next start

  // Every engine result lands in the bank and nothing else is written
  a_wr_with_done: assert property (@(posedge sys_clk) disable iff (!arst_n)
    wr_en == cal.done);

endmodule

// File: src/rxcal_top.sv
//==============================
// Offset calibration top: blocks,
// scan and register override forcing
//==============================
module rxcal_top (
  input  logic                                 sys_clk,
  input  logic                                 arst_n,
  input  logic                                 start_cal,
  input  logic [rxcal_cfg_pkg::NUM_LANES-1:0]  ana_rxdata,
  input  logic                                 ovrd_sel,
  input  logic                                 cal_done_ovrd,
  input  rxcal_cfg_pkg::code_t                 cal_code_ovrd,
  input  logic                                 scan_mode,
  input  logic                                 clk_div_ld,
  input  logic [rxcal_cfg_pkg::DIV_W-1:0]      clk_div_onehot,
  output logic                                 cal_done,
  output logic                                 cal_run,
  output rxcal_cfg_pkg::code_t [rxcal_cfg_pkg::NUM_LANES-1:0] cal_code,
  output logic                                 clk_div_ld_ack
);

  rxcal_cfg_pkg::code_t [rxcal_cfg_pkg::NUM_LANES-1:0] lane_code;  // Bank view
  rxcal_cfg_pkg::lane_t lane;
  logic cal_tick;
  logic cal_active;
  logic wr_en;
  logic cal_done_int;

  rxcal_if u_cal_if ();  // One search at a time

  rxcal_rate_div u_rate_div (
    .sys_clk        (sys_clk),
    .arst_n         (arst_n),
    .clk_div_ld     (clk_div_ld),
    .clk_div_onehot (clk_div_onehot),
    .cal_tick       (cal_tick),
    .clk_div_ld_ack (clk_div_ld_ack)
  );

  rxcal_sar_engine u_sar_engine (
    .sys_clk  (sys_clk),
    .arst_n   (arst_n),
    .cal_tick (cal_tick),
    .cal      (u_cal_if)
  );

  rxcal_code_bank u_code_bank (
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .ana_rxdata (ana_rxdata),
    .lane       (lane),
    .cal_active (cal_active),
    .wr_en      (wr_en),
    .cal        (u_cal_if),
    .lane_code  (lane_code)
  );

  rxcal_sequencer u_sequencer (
    .sys_clk      (sys_clk),
    .arst_n       (arst_n),
    .start_cal    (start_cal),
    .cal          (u_cal_if),
    .lane         (lane),
    .cal_active   (cal_active),
    .wr_en        (wr_en),
    .cal_run      (cal_run),
    .cal_done_int (cal_done_int)
  );

  //==============================
  // Output forcing, scan wins over override
  //==============================
  always_comb
  begin
    for (int i = 0; i < rxcal_cfg_pkg::NUM_LANES; i++)
    begin
      if (scan_mode)
        cal_code[i] = '0;
      else if (ovrd_sel)
        cal_code[i] = cal_code_ovrd;   // Register value on all lanes
      else
        cal_code[i] = lane_code[i];
    end
  end

  assign cal_done = ovrd_sel ? cal_done_ovrd : cal_done_int;

endmodule

// File: tb/tb_rxcal.sv
//==============================
// Offset calibration testbench with comparator model,
// expected-code reference, code and flag checks and timeout
//==============================
module tb_rxcal;

  localparam logic [rxcal_cfg_pkg::DIV_W-1:0] DIV_BY_1 = 7'b000_0001;
  localparam logic [rxcal_cfg_pkg::DIV_W-1:0] DIV_BY_8 = 7'b000_1000;
  // Two full runs at /1 and /8 plus margin for search overhead and short tests
  localparam int CYCLE_LIMIT = rxcal_cfg_pkg::NUM_LANES * rxcal_cfg_pkg::CODE_W *
                               (rxcal_cfg_pkg::SETTLE_TICKS + 1) * (1 + 8) + 1000;
  // Settle ticks alone at /8 set the floor on a full run
  localparam int MIN_CYCLES_DIV8 = rxcal_cfg_pkg::NUM_LANES * rxcal_cfg_pkg::CODE_W *
                                   rxcal_cfg_pkg::SETTLE_TICKS * 8;

  logic                                                sys_clk;
  logic                                                arst_n;
  logic                                                start_cal;
  logic [rxcal_cfg_pkg::NUM_LANES-1:0]                 ana_rxdata;
  logic                                                ovrd_sel;
  logic                                                cal_done_ovrd;
  rxcal_cfg_pkg::code_t                                cal_code_ovrd;
  logic                                                scan_mode;
  logic                                                clk_div_ld;
  logic [rxcal_cfg_pkg::DIV_W-1:0]                     clk_div_onehot;
  logic                                                cal_done;
  logic                                                cal_run;
  rxcal_cfg_pkg::code_t [rxcal_cfg_pkg::NUM_LANES-1:0] cal_code;
  logic                                                clk_div_ld_ack;

  int                   thr [rxcal_cfg_pkg::NUM_LANES];       // Comparator trip points
  rxcal_cfg_pkg::code_t exp_code [rxcal_cfg_pkg::NUM_LANES];  // Expected per lane
  int unsigned          lcg_state;
  logic                 compare_req;   // Asks the comparator process for one pass
  int                   cycle_cnt;
  int                   run_cycles;    // Cycles from run start to done
  int                   n_checks;
  int                   n_errors;
  int                   n_tests;
  int                   n_failed;
  int                   test_err_base;

  rxcal_top u_dut (
    .sys_clk        (sys_clk),
    .arst_n         (arst_n),
    .start_cal      (start_cal),
    .ana_rxdata     (ana_rxdata),
    .ovrd_sel       (ovrd_sel),
    .cal_done_ovrd  (cal_done_ovrd),
    .cal_code_ovrd  (cal_code_ovrd),
    .scan_mode      (scan_mode),
    .clk_div_ld     (clk_div_ld),
    .clk_div_onehot (clk_div_onehot),
    .cal_done       (cal_done),
    .cal_run        (cal_run),
    .cal_code       (cal_code),
    .clk_div_ld_ack (clk_div_ld_ack)
  );

  always #20 sys_clk = ~sys_clk;  // 40 unit period

  //==============================
  // Analog comparator model
  //==============================
  always @(posedge sys_clk)
  begin
    for (int i = 0; i < rxcal_cfg_pkg::NUM_LANES; i++)
      ana_rxdata[i] <= (int'(cal_code[i]) >= thr[i]);  // Trips at or above threshold
  end

  // Run limit
  always @(posedge sys_clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Best code is the last one below the trip point within the code range
  function automatic rxcal_cfg_pkg::code_t expected_code(input int t);
    int code_max;
    code_max = (1 << rxcal_cfg_pkg::CODE_W) - 1;
    if (t <= 0)
      return '0;
    if (t - 1 > code_max)
      return rxcal_cfg_pkg::code_t'(code_max);
    return rxcal_cfg_pkg::code_t'(t - 1);
  endfunction

  task automatic check_code(input string name, input rxcal_cfg_pkg::code_t got,
                            input rxcal_cfg_pkg::code_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // A slower tick stretches every settle wait
  task automatic check_run_length(input string name, input int cycles, input int min_cycles);
    n_checks++;
    if (cycles < min_cycles)
    begin
      n_errors++;
      $display("%s finished after only %0d cycles but needs at least %0d at this rate",
               name, cycles, min_cycles);
    end
  endtask

  //==============================
  // Code comparator pass on request
  //==============================
  always @(negedge sys_clk)
  begin
    if (compare_req)
    begin
      for (int i = 0; i < rxcal_cfg_pkg::NUM_LANES; i++)
        check_code($sformatf("cal_code[%0d]", i), cal_code[i], exp_code[i]);
      compare_req = 1'b0;
    end
  end

  task automatic compare_codes;
    compare_req = 1'b1;
    wait (compare_req == 1'b0);
  endtask

  task automatic draw_thresholds;
    for (int i = 0; i < rxcal_cfg_pkg::NUM_LANES; i++)
    begin
      lcg_state = lcg_next(lcg_state);
      thr[i]    = (lcg_state >> 16) % 33;  // 0 to 32
    end
  endtask

  task automatic expect_all(input rxcal_cfg_pkg::code_t value);
    for (int i = 0; i < rxcal_cfg_pkg::NUM_LANES; i++)
      exp_code[i] = value;
  endtask

  task automatic expect_calibrated;
    for (int i = 0; i < rxcal_cfg_pkg::NUM_LANES; i++)
      exp_code[i] = expected_code(thr[i]);
  endtask

  task automatic begin_test;
    test_err_base = n_errors;
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (n_errors != test_err_base)
      n_failed++;
    $display("test %0d %s %s", n_tests, name, (n_errors == test_err_base) ? "ok" : "FAIL");
  endtask

  // Load a ratio and watch the ack follow ld
  task automatic load_divider(input logic [rxcal_cfg_pkg::DIV_W-1:0] sel);
    @(posedge sys_clk);
    clk_div_ld     <= 1'b1;
    clk_div_onehot <= sel;
    @(negedge sys_clk);
    check_flag("clk_div_ld_ack", clk_div_ld_ack, 1'b0);
    @(negedge sys_clk);
    check_flag("clk_div_ld_ack", clk_div_ld_ack, 1'b1);   // Next cycle
    @(posedge sys_clk);
    clk_div_ld <= 1'b0;
    @(negedge sys_clk);
    check_flag("clk_div_ld_ack", clk_div_ld_ack, 1'b1);   // ld still seen high here
    @(negedge sys_clk);
    check_flag("clk_div_ld_ack", clk_div_ld_ack, 1'b0);   // Cycle after ld falls
  endtask

  // Start edge then wait for done under the run limit
  task automatic run_calibration;
    @(posedge sys_clk);
    start_cal <= 1'b1;
    @(posedge sys_clk);
    @(negedge sys_clk);
    check_flag("cal_run", cal_run, 1'b1);
    check_flag("cal_done", cal_done, 1'b0);
    run_cycles = 0;
    do
    begin
      @(negedge sys_clk);
      run_cycles++;
    end
    while (cal_done !== 1'b1);
    check_flag("cal_run", cal_run, 1'b0);
    @(posedge sys_clk);
    start_cal <= 1'b0;
  endtask

  //==============================
  // Test sequence
  //==============================
  initial
  begin
    sys_clk        = 1'b0;
    arst_n         = 1'b0;
    start_cal      = 1'b0;
    ana_rxdata     = '0;
    ovrd_sel       = 1'b0;
    cal_done_ovrd  = 1'b0;
    cal_code_ovrd  = '0;
    scan_mode      = 1'b0;
    clk_div_ld     = 1'b0;
    clk_div_onehot = DIV_BY_1;
    compare_req    = 1'b0;
    cycle_cnt      = 0;
    run_cycles     = 0;
    n_checks       = 0;
    n_errors       = 0;
    n_tests        = 0;
    n_failed       = 0;
    lcg_state      = 32'd29138;
    draw_thresholds();
    repeat (2) @(posedge sys_clk);
    arst_n <= 1'b1;

    begin_test();
    @(negedge sys_clk);
    check_flag("cal_run", cal_run, 1'b0);
    check_flag("cal_done", cal_done, 1'b0);
    check_flag("clk_div_ld_ack", clk_div_ld_ack, 1'b0);
    @(posedge sys_clk);
    expect_all('0);
    compare_codes();
    end_test("reset state");

    begin_test();
    load_divider(DIV_BY_1);
    end_test("divider load /1");

    begin_test();
    run_calibration();
    expect_calibrated();
    compare_codes();
    end_test("calibration at /1");

    begin_test();
    draw_thresholds();
    thr[2] = 0;    // Trips at once so the code floors at 0
    thr[5] = 32;   // Never trips so the code tops out
    load_divider(DIV_BY_8);
    run_calibration();
    check_run_length("calibration at /8", run_cycles, MIN_CYCLES_DIV8);
    expect_calibrated();
    compare_codes();
    end_test("calibration at /8");

    begin_test();
    @(posedge sys_clk);
    ovrd_sel      <= 1'b1;
    cal_code_ovrd <= 5'h16;
    cal_done_ovrd <= 1'b0;
    expect_all(5'h16);
    compare_codes();
    check_flag("cal_done", cal_done, 1'b0);  // Internal done is high under it
    @(posedge sys_clk);
    cal_done_ovrd <= 1'b1;
    @(negedge sys_clk);
    check_flag("cal_done", cal_done, 1'b1);
    @(posedge sys_clk);
    cal_done_ovrd <= 1'b0;
    @(negedge sys_clk);
    check_flag("cal_done", cal_done, 1'b0);
    end_test("override select");

    begin_test();
    @(posedge sys_clk);
    scan_mode <= 1'b1;     // Override still selected
    expect_all('0);
    compare_codes();
    @(posedge sys_clk);
    scan_mode <= 1'b0;
    ovrd_sel  <= 1'b0;
    expect_calibrated();
    compare_codes();
    check_flag("cal_done", cal_done, 1'b1);
    end_test("scan mode");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: sim.f
src/rxcal_cfg_pkg.sv
src/rxcal_state_pkg.sv
src/rxcal_if.sv
src/rxcal_rate_div.sv
src/rxcal_sar_engine.sv
src/rxcal_code_bank.sv
src/rxcal_sequencer.sv
src/rxcal_top.sv
tb/tb_rxcal.sv

// File: Makefile
# Verilator build for the receiver offset calibration testbench

VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_rxcal
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the testbench prints the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(OBJDIR)
